/* Bender.yml */
package:
  name: ex_stage

sources:
  - src/ex_pkg.sv
  - src/ex_decode.sv
  - src/ex_alu.sv
  - src/hilo_regs.sv
  - src/cp0_exc_fsm.sv
  - src/squash_counter.sv
  - src/pc_redirect.sv
  - src/ex_stage.sv
  - target: simulation
    files:
      - sim/ex_stage_properties.sv
      - sim/tb_ex_stage.sv

/* all.f */
src/ex_pkg.sv
src/ex_decode.sv
src/ex_alu.sv
src/hilo_regs.sv
src/cp0_exc_fsm.sv
src/squash_counter.sv
src/pc_redirect.sv
src/ex_stage.sv
sim/ex_stage_properties.sv
sim/tb_ex_stage.sv

/* sim/ex_stage_properties.sv */
`timescale 1ns/100ps

module ex_stage_properties import ex_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  valid_i,
    input logic  reg_write_o,
    input logic  pc_jump_o,
    input word_t pc_jumpto_o,
    input logic  exception_o
);

    int unsigned fails = 0;

    // Nothing happens without an instruction
    idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        !valid_i |-> !reg_write_o && !pc_jump_o && !exception_o)
        else begin
            fails++;
            $error("write, redirect or exception while valid_i is low");
        end

    exc_vector: assert property (@(posedge clk) disable iff (!rst)
        exception_o |-> pc_jump_o && pc_jumpto_o == EXC_VECTOR)
        else begin
            fails++;
            $error("exception without a redirect to the vector");
        end

    // Idle cycles between the two killed slots don't count
    squash_slots: assert property (@(posedge clk) disable iff (!rst)
        pc_jump_o |=> (valid_i[->1] ##0 !reg_write_o) ##1 (valid_i[->1] ##0 !reg_write_o))
        else begin
            fails++;
            $error("register write inside the two slots after a redirect");
        end

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk(clk), .rst(rst), .valid_i(valid_i), .reg_write_o(reg_write_o),
    .pc_jump_o(pc_jump_o), .pc_jumpto_o(pc_jumpto_o), .exception_o(exception_o)
);

/* sim/tb_ex_stage.sv */
`timescale 1ns/100ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int RESET_CYCLES    = 10;
    localparam int N_RANDOM        = 400;
    localparam int DIRECTED_CYCLES = 100;   // Redirect, HI/LO and exception blocks
    localparam int MAX_CYCLES      = RESET_CYCLES + N_RANDOM + DIRECTED_CYCLES + 20;

    typedef struct packed {
        word_t     result;
        logic      reg_write;
        logic      pc_jump;
        word_t     pc_jumpto;
        logic      exception;
        exc_code_t cause;
    } exp_t;

    logic      clk, rst, valid_i;
    opcode_t   op_i;
    func_t     func_i;
    word_t     data_a_i, data_b_i, simm_i, zimm_i, npc_i;
    jidx_t     jidx_i;
    word_t     result_o, pc_jumpto_o;
    logic      reg_write_o, pc_jump_o, exception_o;
    exc_code_t ex_cause_o;

    exp_t        exp_q;
    string       test_name;
    logic [31:0] seed;
    logic        check_en;
    int          errors, checks, cycles;

    // Reference state
    int    m_squash;
    word_t m_hi, m_lo, m_status, m_cause, m_epc;
    logic  m_exl;

    func_t alu_fns [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                            FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    opcode_t    imm_ops [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    opcode_t    br_ops [4]   = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
    logic [4:0] ri_sels [4]  = '{RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};
    opcode_t    jmp_ops [4]  = '{OP_J, OP_JAL, OP_SPECIAL, OP_SPECIAL};
    func_t      jmp_fns [4]  = '{6'h00, 6'h00, FN_JR, FN_JALR};
    func_t      hilo_fns [4] = '{FN_MTHI, FN_MTLO, FN_MFHI, FN_MFLO};

    ex_stage uut (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Value below n from the upper LCG bits
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    // Expected outputs for one cycle, then advance the model state
    function automatic exp_t ref_step(input logic valid, input opcode_t op, input func_t fn,
                                      input jidx_t idx, input word_t a, input word_t b,
                                      input word_t npc);
        exp_t       e;
        logic       live;
        logic       exc;
        logic       taken;
        exc_code_t  code;
        word_t      simm;
        word_t      zimm;
        logic [4:0] sa;
        logic [4:0] rd;
        live  = valid && (m_squash == 0);
        simm  = {{16{idx[15]}}, idx[15:0]};
        zimm  = {16'h0000, idx[15:0]};
        sa    = idx[10:6];
        rd    = idx[15:11];
        e     = '0;
        exc   = 1'b0;
        taken = 1'b0;
        code  = EXC_RESERVED;
        case (op)
            OP_SPECIAL: begin
                e.reg_write = 1'b1;
                case (fn)
                    FN_ADD, FN_ADDU: e.result = a + b;
                    FN_SUB, FN_SUBU: e.result = a - b;
                    FN_AND:  e.result = a & b;
                    FN_OR:   e.result = a | b;
                    FN_XOR:  e.result = a ^ b;
                    FN_NOR:  e.result = ~(a | b);
                    FN_SLT:  e.result = word_t'($signed(a) < $signed(b));
                    FN_SLTU: e.result = word_t'(a < b);
                    FN_SLL:  e.result = b << sa;
                    FN_SRL:  e.result = b >> sa;
                    FN_SRA:  e.result = word_t'($signed(b) >>> sa);
                    FN_SLLV: e.result = b << a[4:0];
                    FN_SRLV: e.result = b >> a[4:0];
                    FN_SRAV: e.result = word_t'($signed(b) >>> a[4:0]);
                    FN_JR, FN_JALR: begin
                        e.reg_write = (fn == FN_JALR);
                        e.result    = npc + 32'd4;
                        e.pc_jump   = 1'b1;
                        e.pc_jumpto = a;
                    end
                    FN_MTHI, FN_MTLO: begin
                        e.reg_write = 1'b0;
                        if (live && fn == FN_MTHI)
                            m_hi = a;
                        else if (live)
                            m_lo = a;
                    end
                    FN_MFHI: e.result = m_hi;
                    FN_MFLO: e.result = m_lo;
                    default: begin
                        e.reg_write = 1'b0;
                        exc         = 1'b1;
                        if (fn == FN_SYSCALL)
                            code = EXC_SYSCALL;
                        else if (fn == FN_BREAK)
                            code = EXC_BREAK;
                    end
                endcase
            end
            OP_REGIMM: begin
                if (idx[20:16] inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}) begin
                    if (idx[20:16] inside {RI_BGEZ, RI_BGEZAL})
                        taken = ($signed(a) >= 0);
                    else
                        taken = ($signed(a) < 0);
                    e.reg_write = idx[20];            // AL forms link even when not taken
                    e.result    = npc + 32'd4;
                end else begin
                    exc = 1'b1;
                end
            end
            OP_J, OP_JAL: begin
                e.pc_jump   = 1'b1;
                e.pc_jumpto = {npc[31:28], idx, 2'b00};
                e.reg_write = (op == OP_JAL);
                e.result    = npc + 32'd4;
            end
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLEZ: taken = ($signed(a) <= 0);
            OP_BGTZ: taken = ($signed(a) > 0);
            OP_ADDI, OP_ADDIU: begin
                e.reg_write = 1'b1;
                e.result    = a + simm;
            end
            OP_SLTI, OP_SLTIU: begin
                e.reg_write = 1'b1;
                if (op == OP_SLTI)
                    e.result = word_t'($signed(a) < $signed(simm));
                else
                    e.result = word_t'(a < simm);
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                e.reg_write = 1'b1;
                case (op)
                    OP_ANDI: e.result = a & zimm;
                    OP_ORI:  e.result = a | zimm;
                    OP_XORI: e.result = a ^ zimm;
                    default: e.result = {idx[15:0], 16'h0000};
                endcase
            end
            OP_COP0: begin
                if (idx[25:21] == COP0_MF) begin
                    e.reg_write = 1'b1;
                    if (rd == CP0_STATUS)
                        e.result = {m_status[31:2], m_exl, m_status[0]};
                    else if (rd == CP0_CAUSE)
                        e.result = m_cause;
                    else if (rd == CP0_EPC)
                        e.result = m_epc;
                end else if (idx[25:21] == COP0_MT && live) begin
                    if (rd == CP0_STATUS)
                        m_status = b;
                    else if (rd == CP0_CAUSE)
                        m_cause = b;
                    else if (rd == CP0_EPC)
                        m_epc = b;
                end else if (idx[25:21] == COP0_CO && fn == FN_ERET) begin
                    e.pc_jump   = 1'b1;
                    e.pc_jumpto = m_epc;
                    if (live)
                        m_exl = 1'b0;
                end
            end
            default: exc = 1'b1;
        endcase
        if (taken) begin
            e.pc_jump   = 1'b1;
            e.pc_jumpto = npc + (simm << 2);
        end
        if (exc) begin
            e.exception = 1'b1;
            e.cause     = code;
            e.pc_jump   = 1'b1;
            e.pc_jumpto = EXC_VECTOR;
        end
        if (!live) begin
            e = '0;
        end else if (exc) begin
            m_cause[6:2] = code;
            m_epc        = npc - 32'd4;
            m_exl        = 1'b1;
        end
        if (valid && m_squash > 0)
            m_squash--;
        if (e.pc_jump)
            m_squash = SQUASH_SLOTS;
        return e;
    endfunction

    task automatic issue(input string name, input opcode_t op, input func_t fn,
                         input jidx_t idx, input word_t a, input word_t b);
        word_t npc;
        npc = lcg_next();
        @(posedge clk);
        #1;
        test_name = name;
        valid_i   = 1'b1;
        op_i      = op;
        func_i    = fn;
        jidx_i    = idx;
        data_a_i  = a;
        data_b_i  = b;
        simm_i    = {{16{idx[15]}}, idx[15:0]};
        zimm_i    = {16'h0000, idx[15:0]};
        npc_i     = {npc[31:2], 2'b00};
        exp_q     = ref_step(1'b1, op, fn, idx, a, b, npc_i);
    endtask

    // Garbage on the inputs with valid_i low
    task automatic idle();
        @(posedge clk);
        #1;
        test_name = "idle";
        valid_i   = 1'b0;
        op_i      = opcode_t'(lcg_next());
        func_i    = func_t'(lcg_next());
        jidx_i    = jidx_t'(lcg_next());
        data_a_i  = lcg_next();
        data_b_i  = lcg_next();
        exp_q     = ref_step(1'b0, op_i, func_i, jidx_i, data_a_i, data_b_i, npc_i);
    endtask

    task automatic fill();
        word_t a;
        word_t b;
        a = lcg_next();
        b = lcg_next();
        issue("filler", OP_SPECIAL, FN_ADDU, 26'd0, a, b);
    endtask

    // Two killed fillers with an idle cycle between, then a live one
    task automatic redirect_then_fill(input string name, input opcode_t op, input func_t fn,
                                      input jidx_t idx, input word_t a, input word_t b);
        issue(name, op, fn, idx, a, b);
        fill();
        idle();
        fill();
        fill();
    endtask

    task automatic exc_round(input string name, input opcode_t op, input func_t fn);
        issue(name, op, fn, 26'd0, 32'h0000_1111, 32'h0000_2222);
        fill();
        fill();
        issue("mfc0 cause", OP_COP0, 6'h00, {COP0_MF, 5'd0, CP0_CAUSE, 11'd0}, 0, 0);
        issue("mfc0 status", OP_COP0, 6'h00, {COP0_MF, 5'd0, CP0_STATUS, 11'd0}, 0, 0);
        issue("mfc0 epc", OP_COP0, 6'h00, {COP0_MF, 5'd0, CP0_EPC, 11'd0}, 0, 0);
        issue("eret", OP_COP0, FN_ERET, {COP0_CO, 15'd0, FN_ERET}, 0, 0);
        fill();
        fill();
        issue("mfc0 status after eret", OP_COP0, 6'h00,
              {COP0_MF, 5'd0, CP0_STATUS, 11'd0}, 0, 0);
    endtask

    task automatic report_mismatch(input string what, input word_t expv, input word_t act);
        errors++;
        $display("error %s %s expected %h actual %h", test_name, what, expv, act);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            checks++;
            if (reg_write_o !== exp_q.reg_write)
                report_mismatch("reg_write_o", exp_q.reg_write, reg_write_o);
            if (pc_jump_o !== exp_q.pc_jump)
                report_mismatch("pc_jump_o", exp_q.pc_jump, pc_jump_o);
            if (exception_o !== exp_q.exception)
                report_mismatch("exception_o", exp_q.exception, exception_o);
            if (exp_q.reg_write && result_o !== exp_q.result)
                report_mismatch("result_o", exp_q.result, result_o);
            if (exp_q.pc_jump && pc_jumpto_o !== exp_q.pc_jumpto)
                report_mismatch("pc_jumpto_o", exp_q.pc_jumpto, pc_jumpto_o);
            if (exp_q.exception && ex_cause_o !== exp_q.cause)
                report_mismatch("ex_cause_o", exp_q.cause, ex_cause_o);
        end
    end

    initial begin
        int    kind;
        int    j;
        word_t a;
        word_t b;
        jidx_t idx;
        seed      = 32'd75217;
        rst       = 1'b0;
        valid_i   = 1'b0;
        op_i      = '0;
        func_i    = '0;
        data_a_i  = '0;
        data_b_i  = '0;
        simm_i    = '0;
        zimm_i    = '0;
        npc_i     = '0;
        jidx_i    = '0;
        exp_q     = '0;
        test_name = "reset";
        check_en  = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        m_squash  = 0;
        m_hi      = '0;
        m_lo      = '0;
        m_cause   = '0;
        m_epc     = '0;
        m_status  = STATUS_RESET;
        m_exl     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst      = 1'b1;
        check_en = 1'b1;

        for (int i = 0; i < N_RANDOM; i++) begin
            a    = (rand_below(8) == 0) ? 32'd0 : lcg_next();
            b    = (rand_below(4) == 0) ? a : lcg_next();   // Equal operands for BEQ/BNE
            idx  = jidx_t'(lcg_next());
            kind = rand_below(16);
            j    = rand_below(4);
            case (kind)
                0, 1, 2, 3, 4, 5: issue("alu", OP_SPECIAL, alu_fns[rand_below(16)], idx, a, b);
                6, 7, 8, 9: issue("imm", imm_ops[rand_below(8)], 6'h00, idx, a, b);
                10: issue("branch", br_ops[j], 6'h00, idx, a, b);
                11: issue("regimm", OP_REGIMM, 6'h00, {idx[25:21], ri_sels[j], idx[15:0]}, a, b);
                12: issue("jump", jmp_ops[j], jmp_fns[j], idx, a, b);
                13: issue("hilo", OP_SPECIAL, hilo_fns[j], idx, a, b);
                default: idle();
            endcase
        end

        redirect_then_fill("beq taken", OP_BEQ, 6'h00, 26'h0000040, 32'h1234, 32'h1234);
        redirect_then_fill("beq not taken", OP_BEQ, 6'h00, 26'h0000040, 32'h1234, 32'h4321);
        redirect_then_fill("bgezal not taken", OP_REGIMM, 6'h00,
                           {5'd0, RI_BGEZAL, 16'hFFF0}, 32'h8000_0000, 32'd0);
        redirect_then_fill("j", OP_J, 6'h00, 26'h0123456, 32'd0, 32'd0);
        redirect_then_fill("jal", OP_JAL, 6'h00, 26'h0ABCDEF, 32'd0, 32'd0);
        redirect_then_fill("jr", OP_SPECIAL, FN_JR, 26'd0, 32'h0040_1000, 32'd0);
        redirect_then_fill("jalr", OP_SPECIAL, FN_JALR, 26'd0, 32'h0040_2000, 32'd0);

        issue("mthi", OP_SPECIAL, FN_MTHI, 26'd0, 32'hCAFE_0001, 32'd0);
        issue("mtlo", OP_SPECIAL, FN_MTLO, 26'd0, 32'hBEEF_0002, 32'd0);
        fill();
        issue("mfhi", OP_SPECIAL, FN_MFHI, 26'd0, 32'd0, 32'd0);
        issue("mflo", OP_SPECIAL, FN_MFLO, 26'd0, 32'd0, 32'd0);
        issue("j before moves", OP_J, 6'h00, 26'h0000100, 32'd0, 32'd0);
        issue("squashed mthi", OP_SPECIAL, FN_MTHI, 26'd0, 32'h1111_1111, 32'd0);
        issue("squashed mtlo", OP_SPECIAL, FN_MTLO, 26'd0, 32'h2222_2222, 32'd0);
        issue("mfhi kept", OP_SPECIAL, FN_MFHI, 26'd0, 32'd0, 32'd0);
        issue("mflo kept", OP_SPECIAL, FN_MFLO, 26'd0, 32'd0, 32'd0);

        exc_round("syscall", OP_SPECIAL, FN_SYSCALL);
        exc_round("break", OP_SPECIAL, FN_BREAK);
        exc_round("reserved", 6'h3F, 6'h00);

        idle();
        @(negedge clk);
        #1;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_props.fails);
        if (errors == 0 && uut.u_props.fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* src/cp0_exc_fsm.sv */
`timescale 1ns/100ps

module cp0_exc_fsm import ex_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       live_i,
    input  ins_class_e ins_class_i,
    input  jidx_t      jidx_i,
    input  word_t      data_b_i,
    input  word_t      npc_i,
    output logic       exc_redirect_o,
    output word_t      exc_target_o,
    output word_t      cp0_rdata_o,
    output logic       exception_o,
    output exc_code_t  ex_cause_o
);

    exl_state_e state_q, state_d;
    word_t      status_q, cause_q, epc_q;
    word_t      status_rd;
    exc_code_t  exc_code;
    logic       exc_take;
    logic       eret_take;
    logic [4:0] cp0_reg;

    assign cp0_reg   = jidx_i[15:11];  // rd field
    assign exc_take  = live_i && (ins_class_i inside {SYSCALL, BREAK, RESERVED});
    assign eret_take = live_i && (ins_class_i == ERET);

    always_comb begin
        case (ins_class_i)
            SYSCALL: exc_code = EXC_SYSCALL;
            BREAK:   exc_code = EXC_BREAK;
            default: exc_code = EXC_RESERVED;
        endcase
    end

    assign exception_o    = exc_take;
    assign ex_cause_o     = exc_take ? exc_code : '0;
    assign exc_redirect_o = exc_take || eret_take;
    assign exc_target_o   = exc_take ? EXC_VECTOR : epc_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            USER: if (exc_take) state_d = EXL;
            EXL:  if (eret_take) state_d = USER;   // Nested exception stays in EXL
            default: state_d = USER;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state_q <= USER;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            status_q <= STATUS_RESET;
            cause_q  <= '0;
            epc_q    <= '0;
        end else if (exc_take) begin
            cause_q[6:2] <= exc_code;
            epc_q        <= npc_i - 32'd4;
        end else if (live_i && ins_class_i == MTC0) begin
            case (cp0_reg)
                CP0_STATUS: status_q <= data_b_i;
                CP0_CAUSE:  cause_q  <= data_b_i;
                CP0_EPC:    epc_q    <= data_b_i;
                default: ;
            endcase
        end
    end

    // EXL bit follows the FSM
    assign status_rd = {status_q[31:2], state_q == EXL, status_q[0]};

    always_comb begin
        case (cp0_reg)
            CP0_STATUS: cp0_rdata_o = status_rd;
            CP0_CAUSE:  cp0_rdata_o = cause_q;
            CP0_EPC:    cp0_rdata_o = epc_q;
            default:    cp0_rdata_o = '0;
        endcase
    end

endmodule

/* src/ex_alu.sv */
`timescale 1ns/100ps

module ex_alu import ex_pkg::*; (
    input  alu_op_e    alu_op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [4:0] shamt_i,
    output word_t      y_o
);

    word_t sum;
    word_t diff;
    word_t sra_res;
    logic  lt_signed;
    logic  lt_unsigned;

    assign sum         = a_i + b_i;
    assign diff        = a_i - b_i;
    assign sra_res     = $signed(b_i) >>> shamt_i;   // Fill with sign of b
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            ADD:  y_o = sum;
            SUB:  y_o = diff;
            AND:  y_o = a_i & b_i;
            OR:   y_o = a_i | b_i;
            XOR:  y_o = a_i ^ b_i;
            NOR:  y_o = ~(a_i | b_i);
            SLL:  y_o = b_i << shamt_i;
            SRL:  y_o = b_i >> shamt_i;
            SRA:  y_o = sra_res;
            SLT:  y_o = {31'd0, lt_signed};
            SLTU: y_o = {31'd0, lt_unsigned};
            LUI:  y_o = {b_i[15:0], 16'h0000};
            default: y_o = '0;
        endcase
    end

endmodule

/* src/ex_decode.sv */
`timescale 1ns/100ps

module ex_decode import ex_pkg::*; (
    input  opcode_t    op_i,
    input  func_t      func_i,
    input  jidx_t      jidx_i,
    output ins_class_e ins_class_o,
    output alu_op_e    alu_op_o,
    output logic       use_imm_o,
    output logic       zext_imm_o,
    output logic       var_shift_o
);

    always_comb begin
        ins_class_o = RESERVED;
        alu_op_o    = ADD;
        use_imm_o   = 1'b0;
        zext_imm_o  = 1'b0;
        var_shift_o = 1'b0;
        case (op_i)
            OP_SPECIAL: begin
                ins_class_o = ALU;
                case (func_i)
                    FN_ADD, FN_ADDU: alu_op_o = ADD;
                    FN_SUB, FN_SUBU: alu_op_o = SUB;
                    FN_AND:  alu_op_o = AND;
                    FN_OR:   alu_op_o = OR;
                    FN_XOR:  alu_op_o = XOR;
                    FN_NOR:  alu_op_o = NOR;
                    FN_SLT:  alu_op_o = SLT;
                    FN_SLTU: alu_op_o = SLTU;
                    FN_SLL:  alu_op_o = SLL;
                    FN_SRL:  alu_op_o = SRL;
                    FN_SRA:  alu_op_o = SRA;
                    FN_SLLV: begin
                        alu_op_o    = SLL;
                        var_shift_o = 1'b1;
                    end
                    FN_SRLV: begin
                        alu_op_o    = SRL;
                        var_shift_o = 1'b1;
                    end
                    FN_SRAV: begin
                        alu_op_o    = SRA;
                        var_shift_o = 1'b1;
                    end
                    FN_JR:             ins_class_o = JUMP;
                    FN_JALR:           ins_class_o = JUMP_LINK;
                    FN_MTHI, FN_MTLO:  ins_class_o = MT_HILO;
                    FN_MFHI, FN_MFLO:  ins_class_o = MF_HILO;
                    FN_SYSCALL:        ins_class_o = SYSCALL;
                    FN_BREAK:          ins_class_o = BREAK;
                    default:           ins_class_o = RESERVED;
                endcase
            end
            OP_REGIMM: begin
                case (jidx_i[20:16])
                    RI_BLTZ, RI_BGEZ:     ins_class_o = BRANCH;
                    RI_BLTZAL, RI_BGEZAL: ins_class_o = BRANCH_LINK;
                    default:              ins_class_o = RESERVED;
                endcase
            end
            OP_J:    ins_class_o = JUMP;
            OP_JAL:  ins_class_o = JUMP_LINK;
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ins_class_o = BRANCH;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ins_class_o = ALU;
                use_imm_o   = 1'b1;
                zext_imm_o  = (op_i inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
                case (op_i)
                    OP_SLTI:  alu_op_o = SLT;
                    OP_SLTIU: alu_op_o = SLTU;  // Sign-extended, compared unsigned
                    OP_ANDI:  alu_op_o = AND;
                    OP_ORI:   alu_op_o = OR;
                    OP_XORI:  alu_op_o = XOR;
                    OP_LUI:   alu_op_o = LUI;
                    default:  alu_op_o = ADD;
                endcase
            end
            OP_COP0: begin
                case (jidx_i[25:21])
                    COP0_MF: ins_class_o = MFC0;
                    COP0_MT: ins_class_o = MTC0;
                    COP0_CO: begin
                        if (func_i == FN_ERET)
                            ins_class_o = ERET;
                        else
                            ins_class_o = NOP_COP;
                    end
                    default: ins_class_o = NOP_COP;  // Other COP0 forms do nothing
                endcase
            end
            default: ins_class_o = RESERVED;
        endcase
    end

endmodule

/* src/ex_pkg.sv */
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [25:0] jidx_t;      // Also carries rt, rs and rd selectors
    typedef logic [4:0]  exc_code_t;
    typedef logic [1:0]  squash_cnt_t;

    typedef enum logic [3:0] {
        ALU, JUMP, JUMP_LINK, BRANCH, BRANCH_LINK, MT_HILO, MF_HILO,
        MFC0, MTC0, ERET, SYSCALL, BREAK, RESERVED, NOP_COP
    } ins_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLL, SRL, SRA, SLT, SLTU, LUI
    } alu_op_e;

    typedef enum logic { USER, EXL } exl_state_e;

    // Major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03, OP_BEQ    = 6'h04, OP_BNE   = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07, OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0A, OP_SLTIU = 6'h0B;
    localparam opcode_t OP_ANDI    = 6'h0C, OP_ORI    = 6'h0D, OP_XORI  = 6'h0E;
    localparam opcode_t OP_LUI     = 6'h0F, OP_COP0   = 6'h10;

    // SPECIAL function codes
    localparam func_t FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03;
    localparam func_t FN_SLLV = 6'h04, FN_SRLV  = 6'h06, FN_SRAV    = 6'h07;
    localparam func_t FN_JR   = 6'h08, FN_JALR  = 6'h09, FN_SYSCALL = 6'h0C;
    localparam func_t FN_BREAK = 6'h0D, FN_MFHI = 6'h10, FN_MTHI    = 6'h11;
    localparam func_t FN_MFLO = 6'h12, FN_MTLO  = 6'h13, FN_ERET    = 6'h18;
    localparam func_t FN_ADD  = 6'h20, FN_ADDU  = 6'h21, FN_SUB     = 6'h22;
    localparam func_t FN_SUBU = 6'h23, FN_AND   = 6'h24, FN_OR      = 6'h25;
    localparam func_t FN_XOR  = 6'h26, FN_NOR   = 6'h27, FN_SLT     = 6'h2A;
    localparam func_t FN_SLTU = 6'h2B;

    // REGIMM rt selectors with the link flag in bit 4
    localparam logic [4:0] RI_BLTZ = 5'h00, RI_BGEZ = 5'h01;
    localparam logic [4:0] RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11;

    // COP0 rs selectors
    localparam logic [4:0] COP0_MF = 5'h00, COP0_MT = 5'h04, COP0_CO = 5'h10;

    localparam exc_code_t EXC_SYSCALL  = 5'd8;
    localparam exc_code_t EXC_BREAK    = 5'd9;
    localparam exc_code_t EXC_RESERVED = 5'd10;

    localparam word_t EXC_VECTOR   = 32'h80001180;
    localparam word_t STATUS_RESET = 32'h0000FA01;
    localparam word_t LINK_OFFSET  = 32'd4;

    localparam logic [4:0] CP0_STATUS = 5'd12, CP0_CAUSE = 5'd13, CP0_EPC = 5'd14;

    localparam squash_cnt_t SQUASH_SLOTS = 2'd2;

endpackage

/* src/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_i,
    input  opcode_t   op_i,
    input  func_t     func_i,
    input  word_t     data_a_i,
    input  word_t     data_b_i,
    input  word_t     simm_i,
    input  word_t     zimm_i,
    input  word_t     npc_i,
    input  jidx_t     jidx_i,
    output word_t     result_o,
    output logic      reg_write_o,
    output logic      pc_jump_o,
    output word_t     pc_jumpto_o,
    output logic      exception_o,
    output exc_code_t ex_cause_o
);

    ins_class_e ins_class;
    alu_op_e    alu_op;
    logic       live;
    logic       use_imm, zext_imm, var_shift;
    logic       exc_redirect;
    logic [4:0] shamt;
    word_t      alu_b, alu_y;
    word_t      hilo_rdata, cp0_rdata, exc_target;

    ex_decode u_decode (
        .op_i(op_i), .func_i(func_i), .jidx_i(jidx_i),
        .ins_class_o(ins_class), .alu_op_o(alu_op),
        .use_imm_o(use_imm), .zext_imm_o(zext_imm), .var_shift_o(var_shift)
    );

    assign alu_b = use_imm ? (zext_imm ? zimm_i : simm_i) : data_b_i;
    assign shamt = var_shift ? data_a_i[4:0] : zimm_i[10:6];  // sa field sits in the imm

    ex_alu u_alu (
        .alu_op_i(alu_op), .a_i(data_a_i), .b_i(alu_b), .shamt_i(shamt), .y_o(alu_y)
    );

    hilo_regs u_hilo (
        .clk(clk), .rst(rst), .live_i(live), .ins_class_i(ins_class),
        .func_i(func_i), .wdata_i(data_a_i), .rdata_o(hilo_rdata)
    );

    cp0_exc_fsm u_cp0 (
        .clk(clk), .rst(rst), .live_i(live), .ins_class_i(ins_class),
        .jidx_i(jidx_i), .data_b_i(data_b_i), .npc_i(npc_i),
        .exc_redirect_o(exc_redirect), .exc_target_o(exc_target),
        .cp0_rdata_o(cp0_rdata), .exception_o(exception_o), .ex_cause_o(ex_cause_o)
    );

    squash_counter u_squash (
        .clk(clk), .rst(rst), .valid_i(valid_i), .pc_jump_i(pc_jump_o), .live_o(live)
    );

    pc_redirect u_redirect (
        .live_i(live), .ins_class_i(ins_class), .op_i(op_i), .jidx_i(jidx_i),
        .data_a_i(data_a_i), .data_b_i(data_b_i), .simm_i(simm_i), .npc_i(npc_i),
        .exc_redirect_i(exc_redirect), .exc_target_i(exc_target),
        .pc_jump_o(pc_jump_o), .pc_jumpto_o(pc_jumpto_o)
    );

    always_comb begin
        case (ins_class)
            ALU:                    result_o = alu_y;
            JUMP_LINK, BRANCH_LINK: result_o = npc_i + LINK_OFFSET;  // Link value
            MF_HILO:                result_o = hilo_rdata;
            MFC0:                   result_o = cp0_rdata;
            default:                result_o = '0;
        endcase
    end

    // Link branches write whether taken or not
    assign reg_write_o = live && (ins_class inside {ALU, JUMP_LINK, BRANCH_LINK, MF_HILO, MFC0});

endmodule

/* src/hilo_regs.sv */
`timescale 1ns/100ps

module hilo_regs import ex_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       live_i,
    input  ins_class_e ins_class_i,
    input  func_t      func_i,
    input  word_t      wdata_i,
    output word_t      rdata_o
);

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (live_i && ins_class_i == MT_HILO) begin
            if (func_i == FN_MTLO)
                lo_q <= wdata_i;
            else
                hi_q <= wdata_i;   // MTHI
        end
    end

    // MFLO picks LO, MFHI picks HI
    assign rdata_o = (func_i == FN_MFLO) ? lo_q : hi_q;

endmodule

/* src/pc_redirect.sv */
`timescale 1ns/100ps

module pc_redirect import ex_pkg::*; (
    input  logic       live_i,
    input  ins_class_e ins_class_i,
    input  opcode_t    op_i,
    input  jidx_t      jidx_i,
    input  word_t      data_a_i,
    input  word_t      data_b_i,
    input  word_t      simm_i,
    input  word_t      npc_i,
    input  logic       exc_redirect_i,
    input  word_t      exc_target_i,
    output logic       pc_jump_o,
    output word_t      pc_jumpto_o
);

    logic  br_cond;
    logic  is_branch;
    logic  is_jump;
    logic  a_zero;
    word_t br_target;
    word_t j_target;

    assign a_zero    = (data_a_i == '0);
    assign is_branch = ins_class_i inside {BRANCH, BRANCH_LINK};
    assign is_jump   = ins_class_i inside {JUMP, JUMP_LINK};

    always_comb begin
        case (op_i)
            OP_BEQ:    br_cond = (data_a_i == data_b_i);
            OP_BNE:    br_cond = (data_a_i != data_b_i);
            OP_BLEZ:   br_cond = data_a_i[31] || a_zero;
            OP_BGTZ:   br_cond = !data_a_i[31] && !a_zero;
            OP_REGIMM: br_cond = jidx_i[16] ? !data_a_i[31] : data_a_i[31]; // BGEZ or BLTZ
            default:   br_cond = 1'b0;
        endcase
    end

    assign br_target = npc_i + {simm_i[29:0], 2'b00};
    assign j_target  = (op_i == OP_SPECIAL) ? data_a_i : {npc_i[31:28], jidx_i, 2'b00};

    assign pc_jump_o = exc_redirect_i || (live_i && (is_jump || (is_branch && br_cond)));

    // Exception and ERET win
    assign pc_jumpto_o = exc_redirect_i ? exc_target_i :
                         is_jump        ? j_target     : br_target;

endmodule

/* src/squash_counter.sv */
`timescale 1ns/100ps

module squash_counter import ex_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  logic pc_jump_i,
    output logic live_o
);

    squash_cnt_t cnt_q;

    // Idle cycles keep the count
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt_q <= '0;
        end else if (pc_jump_i) begin
            cnt_q <= SQUASH_SLOTS;
        end else if (valid_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 2'd1;
        end
    end

    assign live_o = valid_i && (cnt_q == '0);

endmodule
